// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module cpu_tb -f vlog.f -o cpu_sim
./obj_dir/cpu_sim

// File: testbench/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  logic      clk;
  logic      reset;
  logic      load_en;
  mem_addr_t load_addr;
  word_t     load_data;
  reg_idx_t  dbg_reg_idx;
  word_t     dbg_reg_data;
  logic      fetch_strobe;
  word_t     fetch_opword;
  logic      halted;

  word_t  image [MEM_WORDS];     // Memory image with the program from address 0.
  word_t  model_regs [REG_COUNT];
  word_t  exp_trace [$];         // Opwords the model fetched in order.
  int     prog_len;
  int     fetch_idx;
  int     cycle_count;
  int     cycle_limit;
  string  test_name;
  integer seed = 32955;

  cpu_top u_dut (
    .clk          (clk),
    .reset        (reset),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .dbg_reg_idx  (dbg_reg_idx),
    .dbg_reg_data (dbg_reg_data),
    .fetch_strobe (fetch_strobe),
    .fetch_opword (fetch_opword),
    .halted       (halted)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period.
  end

  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_error(string msg);
    $display("ERROR in %s: %s", test_name, msg);
    stop_run();
  endtask

  task automatic check_word(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_opword(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected opword %h (op %0d), actual %h (op %0d)",
               name, expected, expected[31:26], actual, actual[31:26]);
      stop_run();
    end
  endtask

  function automatic word_t encode_lw(reg_idx_t rd, reg_idx_t rs, logic [15:0] off);
    return {OP_LW, rd, rs, off};
  endfunction

  function automatic word_t encode_alu(opcode_e op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
    return {op, rd, rs, rt, 11'd0};
  endfunction

  // Each instruction is a 5-cycle fetch plus at most 5 execute cycles.
  function automatic int cycle_budget(int n_instr);
    return n_instr * 10 + 2 + 50;
  endfunction

  // Executes the image from PC 0 until HALT.
  function automatic int run_model();
    word_t    opw;
    word_t    addr;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    int       steps;
    logic     done;
    steps = 0;
    done  = 1'b0;
    exp_trace.delete();
    for (int i = 0; i < REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    while (!done && steps < 1000) begin
      opw = image[model_regs[31][7:0]];  // Fetch at PC mod 256.
      exp_trace.push_back(opw);
      model_regs[31] = model_regs[31] + 1;  // PC moves before execute.
      steps++;
      rd = opw[25:21];
      rs = opw[20:16];
      rt = opw[15:11];
      case (opw[31:26])
        6'd2: begin                      // LW.
          addr = model_regs[rs] + {{16{opw[15]}}, opw[15:0]};
          model_regs[rd] = image[addr[7:0]];
        end
        6'd3: model_regs[rd] = model_regs[rs] + model_regs[rt];
        6'd4: model_regs[rd] = model_regs[rs] - model_regs[rt];
        default: done = 1'b1;            // HALT.
      endcase
    end
    return steps;
  endfunction

  task automatic add_word(word_t w);
    image[prog_len] = w;
    prog_len++;
  endtask

  task automatic build_directed();
    prog_len = 0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      image[a] = {8'(a), ~8'(a), 8'(a) ^ 8'h5a, 8'(a) + 8'h33};  // Address-unique fill.
    end
    image[8'h90] = 32'h0000_0085;
    image[8'h91] = 32'hffff_fff0;
    image[8'h92] = 32'h0000_0020;
    add_word(encode_lw(5'd1, 5'd0, 16'h0080));     // Positive offset.
    add_word(encode_lw(5'd4, 5'd0, 16'h0090));     // r4 = 0x85.
    add_word(encode_lw(5'd5, 5'd4, 16'h0000));     // Zero offset.
    add_word(encode_lw(5'd6, 5'd4, 16'hfff0));     // Negative offset.
    add_word(encode_lw(5'd12, 5'd4, 16'hff00));    // Wraps at 256 words.
    add_word(encode_lw(5'd7, 5'd0, 16'h0091));
    add_word(encode_lw(5'd8, 5'd0, 16'h0092));
    add_word(encode_alu(OP_ADD, 5'd9, 5'd7, 5'd8));   // Carry out is lost.
    add_word(encode_alu(OP_SUB, 5'd10, 5'd8, 5'd7));
    add_word(encode_alu(OP_SUB, 5'd11, 5'd0, 5'd8));  // Borrow wrap.
    add_word(encode_alu(OP_ADD, 5'd7, 5'd7, 5'd7));   // rD equal to rS.
    add_word(encode_alu(OP_SUB, 5'd8, 5'd8, 5'd9));
    add_word(encode_lw(5'd13, 5'd31, 16'h0010));   // Based on the PC.
    add_word({OP_HALT, 26'd0});
  endtask

  task automatic build_random();
    int       pick;
    reg_idx_t rd;
    prog_len = 0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      image[a] = word_t'($random(seed));
    end
    for (int i = 0; i < 40; i++) begin
      pick = (int'($random(seed)) & 32'h7fff_ffff) % 3;
      rd   = reg_idx_t'((int'($random(seed)) & 32'h7fff_ffff) % 31);  // Never r31.
      case (pick)
        0:       add_word(encode_lw(rd, 5'($random(seed)), 16'($random(seed))));
        1:       add_word(encode_alu(OP_ADD, rd, 5'($random(seed)), 5'($random(seed))));
        default: add_word(encode_alu(OP_SUB, rd, 5'($random(seed)), 5'($random(seed))));
      endcase
    end
    add_word({OP_HALT, 26'd0});
  endtask

  // Writes the whole image while the CPU is held in reset.
  task automatic load_image();
    @(negedge clk);
    reset = 1'b1;
    for (int a = 0; a < MEM_WORDS; a++) begin
      load_en   = 1'b1;
      load_addr = mem_addr_t'(a);
      load_data = image[a];
      @(negedge clk);
    end
    load_en = 1'b0;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    if (halted || fetch_strobe) begin
      report_error("halted or fetch_strobe high right after reset");
    end
  endtask

  task automatic read_register(reg_idx_t idx, output word_t value);
    @(negedge clk);
    dbg_reg_idx = idx;
    @(posedge clk);
    value = dbg_reg_data;
  endtask

  task automatic check_registers();
    word_t value;
    for (int i = 0; i < REG_COUNT; i++) begin
      read_register(reg_idx_t'(i), value);
      check_word($sformatf("%s r%0d", test_name, i), model_regs[i], value);
    end
  endtask

  // HALT must hold with no more fetches and the PC one past the HALT word.
  task automatic check_halt_hold();
    int    fetches;
    word_t pc;
    fetches = fetch_idx;
    repeat (10) begin
      @(negedge clk);
      if (!halted) begin
        report_error("halted dropped after HALT");
      end
    end
    if (fetch_idx != fetches || fetches != exp_trace.size()) begin
      report_error("number of fetches differs from the program trace");
    end
    read_register(REG_PC, pc);
    check_word({test_name, " r31 after HALT"}, word_t'(prog_len), pc);
  endtask

  task automatic wait_halt();
    while (!halted) @(negedge clk);
  endtask

  task automatic run_program(string name);
    int n_instr;
    @(negedge clk);
    test_name   = name;
    n_instr     = run_model();
    cycle_limit = cycle_limit + cycle_budget(n_instr);
    load_image();
    apply_reset();
    wait_halt();
    check_halt_hold();
    check_registers();
  endtask

  // Compares each fetched opword with the model trace from the first word after reset.
  always @(posedge clk) begin
    if (reset) begin
      fetch_idx <= 0;
    end else if (fetch_strobe) begin
      if (fetch_idx >= exp_trace.size()) begin
        report_error("fetch_strobe after the model reached HALT");
      end else begin
        check_opword($sformatf("%s fetch %0d", test_name, fetch_idx),
                     exp_trace[fetch_idx], fetch_opword);
      end
      fetch_idx <= fetch_idx + 1;
    end
  end

  // Counts only running cycles.
  always @(posedge clk) begin
    if (!reset && !halted) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
        $display("timeout: CPU never halted");
        stop_run();
      end
    end
  end

  initial begin
    int n_instr;
    reset       = 1'b1;
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    dbg_reg_idx = '0;
    cycle_count = 0;
    cycle_limit = 0;
    test_name   = "setup";
    build_directed();
    run_program("directed");
    build_random();
    run_program("random");
    build_directed();
    @(negedge clk);
    test_name   = "reset_mid_run";
    n_instr     = run_model();
    cycle_limit = cycle_limit + 2 * cycle_budget(n_instr);  // Aborted run plus full rerun.
    load_image();
    apply_reset();
    while (fetch_idx < 5 && !halted) @(negedge clk);
    if (halted) begin
      report_error("CPU halted before the fifth fetch");
    end
    apply_reset();                       // Mid-program restart.
    wait_halt();
    check_halt_hold();
    check_registers();
    $display("Test OK");
    $finish;
  end
endmodule

// File: verilog/control_logic.sv
module control_logic import cpu_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  output uaddr_t         uaddr,
  input  control_word_t  control_word,
  datapath_if.control    dp,
  output logic           fetch_strobe,
  output word_t          fetch_opword,
  output logic           halted
);
  opcode_e    opcode_q;    // Current instruction, also the state.
  uop_count_t count_q;     // Micro-op within the instruction.
  word_t      opword_q;    // Fetched instruction word.
  word_t      bus;

  logic [5:0] ctrl_data;
  reg_sel_t   reg_sel;
  out_plane_t out_plane;
  in_plane_t  in_plane;
  logic       misc;
  logic       opcode_sel;
  logic       opcode_we;
  logic [OPW_OFFSET_MSB-OPW_OFFSET_LSB:0] offset;

  assign ctrl_data  = control_word[CW_CTRL_DATA_MSB:CW_CTRL_DATA_LSB];
  assign reg_sel    = control_word[CW_REG_SEL_MSB:CW_REG_SEL_LSB];
  assign out_plane  = control_word[CW_OUT_PLANE_MSB:CW_OUT_PLANE_LSB];
  assign in_plane   = control_word[CW_IN_PLANE_MSB:CW_IN_PLANE_LSB];
  assign misc       = control_word[CW_MISC_BIT];
  assign opcode_sel = control_word[CW_OPCODE_SEL_BIT];
  assign offset     = opword_q[OPW_OFFSET_MSB:OPW_OFFSET_LSB];

  assign uaddr = {opcode_q, count_q};  // Opcode in the high bits.

  always_comb begin
    case (reg_sel)
      REG_SEL_RD:      dp.reg_idx = opword_q[OPW_RD_MSB:OPW_RD_LSB];
      REG_SEL_RS:      dp.reg_idx = opword_q[OPW_RS_MSB:OPW_RS_LSB];
      REG_SEL_RT:      dp.reg_idx = opword_q[OPW_RT_MSB:OPW_RT_LSB];
      REG_SEL_CONTROL: dp.reg_idx = ctrl_data[REG_IDX_W-1:0];
      default:         dp.reg_idx = '0;
    endcase
  end

  always_comb begin
    case (out_plane)
      OUT_NONE:      bus = '0;
      OUT_REG:       bus = dp.reg_rdata;
      OUT_MMU:       bus = dp.mem_rdata;
      OUT_MLU:       bus = dp.mlu_result;
      OUT_CTRL_DATA: bus = word_t'(ctrl_data);  // Zero-extended.
      OUT_OFFSET:    bus = {{(WORD_W-$bits(offset)){offset[$bits(offset)-1]}}, offset};
      default:       bus = '0;
    endcase
  end

  assign dp.bus     = bus;
  assign dp.reg_we  = (in_plane == IN_REG);
  assign dp.tmp0_we = (in_plane == IN_TMP0);
  assign dp.tmp1_we = (in_plane == IN_TMP1);
  assign dp.mlu_op  = control_word[CW_MLU_OP_MSB:CW_MLU_OP_LSB];
  assign opcode_we  = (in_plane == IN_OPCODE);

  always_ff @(posedge clk) begin
    if (reset) begin
      opcode_q <= OP_RESET;
      count_q  <= '0;
      opword_q <= '0;
    end else begin
      count_q <= misc ? '0 : count_q + 1'b1;  // Sequence ends on misc.
      if (in_plane == IN_OPWORD) begin
        opword_q <= bus;
      end
      if (opcode_we) begin
        if (opcode_sel == OPCODE_SEL_BUS) begin
          opcode_q <= opcode_e'(bus[OPCODE_W-1:0]);
        end else begin
          opcode_q <= opcode_e'(opword_q[OPW_OPCODE_MSB:OPW_OPCODE_LSB]);
        end
      end
    end
  end

  // Pulses once per instruction, when the fetched opcode is taken.
  assign fetch_strobe = opcode_we && (opcode_sel == OPCODE_SEL_OPWORD);
  assign fetch_opword = opword_q;
  assign halted       = (opcode_q == OP_HALT);
endmodule

// File: verilog/cpu_pkg.sv
package cpu_pkg;
  localparam int WORD_W      = 32;                    // Bus and register width.
  localparam int REG_IDX_W   = 5;                     // Register number width.
  localparam int REG_COUNT   = 32;                    // r0 to r31.
  localparam int UOP_COUNT_W = 5;                     // Micro-op counter width.
  localparam int OPCODE_W    = 6;                     // Opcode field width.
  localparam int UADDR_W     = OPCODE_W + UOP_COUNT_W; // Opcode then count.
  localparam int MEM_ADDR_W  = 8;                     // Word address width.
  localparam int MEM_WORDS   = 256;                   // Words of memory.

  typedef logic [WORD_W-1:0]      word_t;
  typedef logic [REG_IDX_W-1:0]   reg_idx_t;
  typedef logic [UOP_COUNT_W-1:0] uop_count_t;
  typedef logic [UADDR_W-1:0]     uaddr_t;
  typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
  typedef logic [31:0]            control_word_t;
  typedef logic [3:0]             out_plane_t;
  typedef logic [2:0]             in_plane_t;
  typedef logic [1:0]             reg_sel_t;
  typedef logic [2:0]             mlu_op_t;

  // The opcode register doubles as the CPU state.
  typedef enum logic [OPCODE_W-1:0] {
    OP_RESET = 6'd0,
    OP_FETCH = 6'd1,
    OP_LW    = 6'd2,  // LW rD, [rS + offset].
    OP_ADD   = 6'd3,  // rD = rS + rT.
    OP_SUB   = 6'd4,  // rD = rS - rT.
    OP_HALT  = 6'd5
  } opcode_e;

  localparam out_plane_t OUT_NONE      = 4'd0;  // Bus reads zero.
  localparam out_plane_t OUT_REG       = 4'd1;
  localparam out_plane_t OUT_MMU       = 4'd4;
  localparam out_plane_t OUT_MLU       = 4'd5;
  localparam out_plane_t OUT_CTRL_DATA = 4'd8;  // Zero-extended ctrl_data.
  localparam out_plane_t OUT_OFFSET    = 4'd9;  // Sign-extended opword offset.

  localparam in_plane_t IN_NONE   = 3'd0;
  localparam in_plane_t IN_REG    = 3'd1;
  localparam in_plane_t IN_TMP0   = 3'd2;
  localparam in_plane_t IN_TMP1   = 3'd3;
  localparam in_plane_t IN_OPWORD = 3'd5;
  localparam in_plane_t IN_OPCODE = 3'd6;

  localparam reg_sel_t REG_SEL_RD      = 2'd0;
  localparam reg_sel_t REG_SEL_RS      = 2'd1;
  localparam reg_sel_t REG_SEL_CONTROL = 2'd2;  // Index from ctrl_data.
  localparam reg_sel_t REG_SEL_RT      = 2'd3;

  localparam mlu_op_t MLU_ADD = 3'd0;
  localparam mlu_op_t MLU_SUB = 3'd1;
  localparam mlu_op_t MLU_AND = 3'd2;
  localparam mlu_op_t MLU_OR  = 3'd3;
  localparam mlu_op_t MLU_XOR = 3'd4;

  localparam logic OPCODE_SEL_OPWORD = 1'b0;  // Opcode from opword[31:26].
  localparam logic OPCODE_SEL_BUS    = 1'b1;  // Opcode from bus[5:0].

  // Control word layout.
  localparam int CW_CTRL_DATA_LSB = 0;
  localparam int CW_CTRL_DATA_MSB = 5;
  localparam int CW_REG_SEL_LSB   = 6;
  localparam int CW_REG_SEL_MSB   = 7;
  localparam int CW_OUT_PLANE_LSB = 8;
  localparam int CW_OUT_PLANE_MSB = 11;
  localparam int CW_IN_PLANE_LSB  = 12;
  localparam int CW_IN_PLANE_MSB  = 14;
  localparam int CW_MISC_BIT      = 15;  // Micro-op counter reset.
  localparam int CW_MLU_OP_LSB    = 16;
  localparam int CW_MLU_OP_MSB    = 18;
  localparam int CW_MLU_CARRY_BIT = 19;
  localparam int CW_SHIFTER_LSB   = 20;
  localparam int CW_SHIFTER_MSB   = 21;
  localparam int CW_OPCODE_SEL_BIT = 22;

  // Opword layout.
  localparam int OPW_OPCODE_LSB = 26;
  localparam int OPW_OPCODE_MSB = 31;
  localparam int OPW_RD_LSB     = 21;
  localparam int OPW_RD_MSB     = 25;
  localparam int OPW_RS_LSB     = 16;
  localparam int OPW_RS_MSB     = 20;
  localparam int OPW_RT_LSB     = 11;
  localparam int OPW_RT_MSB     = 15;
  localparam int OPW_OFFSET_LSB = 0;
  localparam int OPW_OFFSET_MSB = 15;

  localparam reg_idx_t REG_PC = 5'd31;  // r31 holds the program counter.
endpackage

// File: verilog/cpu_top.sv
module cpu_top import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      load_en,
  input  mem_addr_t load_addr,
  input  word_t     load_data,
  input  reg_idx_t  dbg_reg_idx,
  output word_t     dbg_reg_data,
  output logic      fetch_strobe,
  output word_t     fetch_opword,
  output logic      halted
);
  uaddr_t        uaddr;
  control_word_t control_word;

  datapath_if dp ();  // Control to datapath wiring.

  microcode u_microcode (
    .uaddr        (uaddr),
    .control_word (control_word)
  );

  control_logic u_control (
    .clk          (clk),
    .reset        (reset),
    .uaddr        (uaddr),
    .control_word (control_word),
    .dp           (dp.control),
    .fetch_strobe (fetch_strobe),
    .fetch_opword (fetch_opword),
    .halted       (halted)
  );

  register_file u_regs (
    .clk          (clk),
    .reset        (reset),
    .dp           (dp.regs),
    .dbg_reg_idx  (dbg_reg_idx),
    .dbg_reg_data (dbg_reg_data)
  );

  mlu u_mlu (
    .clk   (clk),
    .reset (reset),
    .dp    (dp.alu)
  );

  mmu u_mmu (
    .clk       (clk),
    .dp        (dp.mem),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );
endmodule

// File: verilog/datapath_if.sv
interface datapath_if import cpu_pkg::*; ();
  word_t    bus;         // Shared data bus.
  reg_idx_t reg_idx;     // Selected register.
  logic     reg_we;      // Register write from bus.
  logic     tmp0_we;     // TMP0 load from bus.
  logic     tmp1_we;     // TMP1 load from bus.
  mlu_op_t  mlu_op;
  word_t    reg_rdata;
  word_t    mlu_result;
  word_t    tmp0;        // Also the memory address.
  word_t    mem_rdata;

  modport control (
    output bus, reg_idx, reg_we, tmp0_we, tmp1_we, mlu_op,
    input  reg_rdata, mlu_result, mem_rdata
  );

  modport regs (
    input  bus, reg_idx, reg_we,
    output reg_rdata
  );

  modport alu (
    input  bus, tmp0_we, tmp1_we, mlu_op,
    output mlu_result, tmp0
  );

  modport mem (
    input  tmp0,
    output mem_rdata
  );
endinterface

// File: verilog/microcode.sv
module microcode import cpu_pkg::*; (
  input  uaddr_t        uaddr,
  output control_word_t control_word
);
  opcode_e    opcode;
  uop_count_t count;

  logic [5:0] ctrl_data;
  reg_sel_t   reg_sel;
  out_plane_t out_plane;
  in_plane_t  in_plane;
  logic       misc;        // Counter reset.
  mlu_op_t    mlu_op;
  logic       opcode_sel;

  assign opcode = opcode_e'(uaddr[UADDR_W-1:UOP_COUNT_W]);
  assign count  = uaddr[UOP_COUNT_W-1:0];

  always_comb begin
    ctrl_data  = '0;               // Everything idle by default.
    reg_sel    = REG_SEL_RD;
    out_plane  = OUT_NONE;
    in_plane   = IN_NONE;
    misc       = 1'b0;
    mlu_op     = MLU_ADD;
    opcode_sel = OPCODE_SEL_OPWORD;
    case (opcode)
      OP_RESET: begin
        case (count)
          5'd0: begin              // r31 = 0 from the idle bus.
            ctrl_data = 6'(REG_PC);
            reg_sel   = REG_SEL_CONTROL;
            in_plane  = IN_REG;
          end
          5'd1: begin              // Go to fetch.
            ctrl_data  = OP_FETCH;
            out_plane  = OUT_CTRL_DATA;
            in_plane   = IN_OPCODE;
            opcode_sel = OPCODE_SEL_BUS;
            misc       = 1'b1;
          end
          default: misc = 1'b1;
        endcase
      end
      OP_FETCH: begin
        case (count)
          5'd0: begin              // PC into TMP0 as memory address.
            ctrl_data = 6'(REG_PC);
            reg_sel   = REG_SEL_CONTROL;
            out_plane = OUT_REG;
            in_plane  = IN_TMP0;
          end
          5'd1: begin              // Memory word into opword.
            out_plane = OUT_MMU;
            in_plane  = IN_OPWORD;
          end
          5'd2: begin              // Increment constant into TMP1.
            ctrl_data = 6'd1;
            out_plane = OUT_CTRL_DATA;
            in_plane  = IN_TMP1;
          end
          5'd3: begin              // PC = PC + 1.
            ctrl_data = 6'(REG_PC);
            reg_sel   = REG_SEL_CONTROL;
            out_plane = OUT_MLU;
            in_plane  = IN_REG;
            mlu_op    = MLU_ADD;
          end
          5'd4: begin              // Decode opword opcode.
            in_plane   = IN_OPCODE;
            opcode_sel = OPCODE_SEL_OPWORD;
            misc       = 1'b1;
          end
          default: misc = 1'b1;
        endcase
      end
      OP_LW: begin
        case (count)
          5'd0: begin              // Base register into TMP1.
            reg_sel   = REG_SEL_RS;
            out_plane = OUT_REG;
            in_plane  = IN_TMP1;
          end
          5'd1: begin              // Offset into TMP0.
            out_plane = OUT_OFFSET;
            in_plane  = IN_TMP0;
          end
          5'd2: begin              // Effective address into TMP0.
            out_plane = OUT_MLU;
            in_plane  = IN_TMP0;
            mlu_op    = MLU_ADD;
          end
          5'd3: begin              // Loaded word into rD.
            reg_sel   = REG_SEL_RD;
            out_plane = OUT_MMU;
            in_plane  = IN_REG;
          end
          5'd4: begin              // Back to fetch.
            ctrl_data  = OP_FETCH;
            out_plane  = OUT_CTRL_DATA;
            in_plane   = IN_OPCODE;
            opcode_sel = OPCODE_SEL_BUS;
            misc       = 1'b1;
          end
          default: misc = 1'b1;
        endcase
      end
      OP_ADD, OP_SUB: begin
        case (count)
          5'd0: begin              // rS into TMP0.
            reg_sel   = REG_SEL_RS;
            out_plane = OUT_REG;
            in_plane  = IN_TMP0;
          end
          5'd1: begin              // rT into TMP1.
            reg_sel   = REG_SEL_RT;
            out_plane = OUT_REG;
            in_plane  = IN_TMP1;
          end
          5'd2: begin              // Result into rD.
            reg_sel   = REG_SEL_RD;
            out_plane = OUT_MLU;
            in_plane  = IN_REG;
            mlu_op    = (opcode == OP_SUB) ? MLU_SUB : MLU_ADD;
          end
          5'd3: begin              // Back to fetch.
            ctrl_data  = OP_FETCH;
            out_plane  = OUT_CTRL_DATA;
            in_plane   = IN_OPCODE;
            opcode_sel = OPCODE_SEL_BUS;
            misc       = 1'b1;
          end
          default: misc = 1'b1;
        endcase
      end
      default: misc = 1'b1;        // HALT and unknown opcodes spin here.
    endcase
  end

  always_comb begin
    control_word = '0;             // Carry, shifter and bits 31..23 stay zero.
    control_word[CW_CTRL_DATA_MSB:CW_CTRL_DATA_LSB] = ctrl_data;
    control_word[CW_REG_SEL_MSB:CW_REG_SEL_LSB]     = reg_sel;
    control_word[CW_OUT_PLANE_MSB:CW_OUT_PLANE_LSB] = out_plane;
    control_word[CW_IN_PLANE_MSB:CW_IN_PLANE_LSB]   = in_plane;
    control_word[CW_MISC_BIT]                       = misc;
    control_word[CW_MLU_OP_MSB:CW_MLU_OP_LSB]       = mlu_op;
    control_word[CW_OPCODE_SEL_BIT]                 = opcode_sel;
  end
endmodule

// File: verilog/mlu.sv
module mlu import cpu_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  datapath_if.alu dp
);
  word_t tmp0_q;  // Left operand, also memory address.
  word_t tmp1_q;  // Right operand.

  always_ff @(posedge clk) begin
    if (reset) begin
      tmp0_q <= '0;
      tmp1_q <= '0;
    end else begin
      if (dp.tmp0_we) begin
        tmp0_q <= dp.bus;
      end
      if (dp.tmp1_we) begin
        tmp1_q <= dp.bus;
      end
    end
  end

  always_comb begin
    case (dp.mlu_op)
      MLU_ADD: dp.mlu_result = tmp0_q + tmp1_q;  // Wraps mod 2^32.
      MLU_SUB: dp.mlu_result = tmp0_q - tmp1_q;
      MLU_AND: dp.mlu_result = tmp0_q & tmp1_q;
      MLU_OR:  dp.mlu_result = tmp0_q | tmp1_q;
      MLU_XOR: dp.mlu_result = tmp0_q ^ tmp1_q;
      default: dp.mlu_result = '0;
    endcase
  end

  assign dp.tmp0 = tmp0_q;
endmodule

// File: verilog/mmu.sv
module mmu import cpu_pkg::*; (
  input  logic      clk,
  datapath_if.mem   dp,
  input  logic      load_en,
  input  mem_addr_t load_addr,
  input  word_t     load_data
);
  word_t     mem [MEM_WORDS];  // Contents survive reset.
  mem_addr_t rd_addr;

  assign rd_addr = dp.tmp0[MEM_ADDR_W-1:0];  // Address wraps at 256 words.

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;  // External program load.
    end
  end

  assign dp.mem_rdata = mem[rd_addr];  // Combinational read.
endmodule

// File: verilog/register_file.sv
module register_file import cpu_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  datapath_if.regs dp,
  input  reg_idx_t dbg_reg_idx,
  output word_t    dbg_reg_data
);
  word_t regs [REG_COUNT];  // r31 is the PC, written like any other.

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (dp.reg_we) begin
      regs[dp.reg_idx] <= dp.bus;
    end
  end

  assign dp.reg_rdata = regs[dp.reg_idx];    // Bus read port.
  assign dbg_reg_data = regs[dbg_reg_idx];   // Debug read port.
endmodule

// File: vlog.f
verilog/cpu_pkg.sv
verilog/datapath_if.sv
verilog/microcode.sv
verilog/control_logic.sv
verilog/register_file.sv
verilog/mlu.sv
verilog/mmu.sv
verilog/cpu_top.sv
testbench/cpu_tb.sv
